//--- build.sh
#!/bin/sh
# compile and run the frame_sync testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

if ! verilator --binary --timing --top-module frame_sync_tb -f frame_sync.f -o frame_sync_sim; then
    echo "build failed"
    exit 1
fi

./obj_dir/frame_sync_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

exit 0

//--- frame_sync.f
+incdir+verilog
verilog/frame_sync_pkg.sv
verilog/frame_timing_if.sv
verilog/pss_scheduler.sv
verilog/symbol_timer.sv
verilog/frame_tagger.sv
verilog/frame_sync.sv
verification/frame_sync_tb.sv

//--- verification/frame_sync_tb.sv
`include "frame_sync_config.svh"

module frame_sync_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import frame_sync_pkg::*;

    localparam int PERIOD_TIMEOUT = 80000;
    localparam int SHORT_TIMEOUT  = 2000;

    logic                 clk;
    logic                 rst_n;
    logic [`FS_IN_DW-1:0] in_data;
    logic                 in_valid;
    logic                 nid_valid;
    logic                 ibar_valid;
    pss_mode_t            pss_mode;
    logic [`FS_IN_DW-1:0] out_data;
    logic [23:0]          out_user;
    logic                 out_last;
    logic                 out_valid;
    logic                 sym_start;
    logic                 ssb_start;
    sync_state_t          state;
    mismatch_t            mismatch;
    logic [15:0]          missed_ssbs;

    // reference model of the timer
    sync_state_t          m_state;
    logic                 m_win;
    logic                 m_ssb;
    mismatch_t            m_mismatch;
    sfn_t                 m_sfn;
    subframe_t            m_sf;
    symbol_t              m_sym;
    cp_len_t              m_cp;
    sample_cnt_t          m_cnt;
    int                   m_syms;

    // expected output two samples deep
    logic [`FS_IN_DW-1:0] q1_data, q2_data;
    logic [23:0]          q1_tag, q2_tag;
    logic                 q1_valid, q2_valid, q1_last, q2_last, q1_first, q2_first;

    logic [31:0]          lfsr_q;

    // one row per SSB period
    int        row_offset   [4] = '{0, 2, -2, 0};
    logic      row_missing  [4] = '{1'b0, 1'b0, 1'b0, 1'b1};
    mismatch_t row_mismatch [4] = '{8'sd0, 8'sd2, -8'sd2, 8'sd0};

    frame_sync dut (
        .clk_i                (clk),
        .reset_ni             (rst_n),
        .s_axis_in_tdata_i    (in_data),
        .s_axis_in_tvalid_i   (in_valid),
        .n_id_2_valid_i       (nid_valid),
        .ibar_ssb_valid_i     (ibar_valid),
        .pss_detector_mode_o  (pss_mode),
        .m_axis_out_tdata_o   (out_data),
        .m_axis_out_tuser_o   (out_user),
        .m_axis_out_tlast_o   (out_last),
        .m_axis_out_tvalid_o  (out_valid),
        .symbol_start_o       (sym_start),
        .ssb_start_o          (ssb_start),
        .state_o              (state),
        .sample_cnt_mismatch_o(mismatch),
        .missed_ssbs_o        (missed_ssbs)
    );

    always #4 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [`FS_IN_DW-1:0] lfsr_word();
        logic [`FS_IN_DW-1:0] w;
        for (int i = 0; i < `FS_IN_DW; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    task automatic check_tag(input string name, input logic [23:0] got, input logic [23:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input logic [`FS_IN_DW-1:0] got,
                              input logic [`FS_IN_DW-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_state(input string name, input sync_state_t got, input sync_state_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_mode(input string name, input pss_mode_t got, input pss_mode_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_mismatch(input string name, input mismatch_t got, input mismatch_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // first sample position of the symbol after the current one
    task automatic next_position(output sfn_t n_sfn, output subframe_t n_sf,
                                 output symbol_t n_sym, output cp_len_t n_cp);
        n_sfn = m_sfn;
        n_sf  = m_sf;
        n_sym = m_sym + 1'b1;
        if (int'(m_sym) == `FS_SYM_PER_SF - 1) begin
            n_sym = '0;
            if (int'(m_sf) == `FS_SF_PER_FRAME - 1) begin
                n_sf  = '0;
                n_sfn = (int'(m_sfn) + 1 == `FS_SFN_MAX) ? '0 : m_sfn + 1'b1;
            end else begin
                n_sf = m_sf + 1'b1;
            end
        end
        n_cp = (int'(n_sym) == 0 || int'(n_sym) == 7) ? cp_len_t'(`FS_CP1_LEN)
                                                      : cp_len_t'(`FS_CP2_LEN);
    endtask

    // drive one cycle of inputs and predict what the DUT does with it
    task automatic apply(input logic v, input logic nid, input logic ibar);
        logic [`FS_IN_DW-1:0] data;
        logic        late, in_win, acq, hit, locked, sym_end;
        sfn_t        e_sfn, a_sfn;
        subframe_t   e_sf, a_sf;
        symbol_t     e_sym, a_sym;
        cp_len_t     e_cp, a_cp;
        sample_cnt_t e_cnt;
        int          symlen;
        data = '0;
        if (v) begin
            data = lfsr_word();
        end
        in_data    = data;
        in_valid   = v;
        nid_valid  = nid;
        ibar_valid = ibar;

        symlen = `FS_FFT_LEN + int'(m_cp);
        late   = int'(m_cnt) < `FS_LATE_LIMIT;
        in_win = m_win && (late || int'(m_cnt) >= symlen - `FS_FIND_EARLY);
        acq    = (m_state == WAIT_FOR_SSB) && nid;
        hit    = in_win && nid;
        locked = (m_state != WAIT_FOR_SSB) || acq;
        next_position(a_sfn, a_sf, a_sym, a_cp);

        e_sfn = m_sfn;
        e_sf  = m_sf;
        e_sym = m_sym;
        e_cp  = m_cp;
        e_cnt = m_cnt;
        if (acq) begin
            e_sym = 4'd2;
            e_cp  = cp_len_t'(`FS_CP2_LEN);
            e_cnt = '0;
        end else if (hit) begin
            e_cnt = '0;
            if (!late) begin
                e_sfn = a_sfn;
                e_sf  = a_sf;
                e_sym = a_sym;
                e_cp  = a_cp;
            end
        end
        sym_end = int'(e_cnt) == `FS_FFT_LEN + int'(e_cp) - 1;

        q2_data  = q1_data;
        q2_tag   = q1_tag;
        q2_valid = q1_valid;
        q2_last  = q1_last;
        q2_first = q1_first;
        q1_data  = data;
        q1_tag   = {e_sfn, e_sf, e_sym, e_cp};
        q1_valid = v;
        q1_last  = v && sym_end;
        q1_first = locked && v && (int'(e_cnt) == 0);
        m_ssb    = hit;

        // state and window use the position before this sample
        case (m_state)
            WAIT_FOR_SSB: if (nid) m_state = WAIT_FOR_IBAR;
            WAIT_FOR_IBAR: if (ibar) m_state = SYNCED;
            default: begin
                if (hit) begin
                    m_win = 1'b0;
                    if (int'(m_cnt) == 0) begin
                        m_mismatch = '0;
                    end else if (late) begin
                        m_mismatch = mismatch_t'(int'(m_cnt));
                    end else begin
                        m_mismatch = mismatch_t'(int'(m_cnt) - symlen);
                    end
                end else if (m_win && v && int'(m_cnt) == `FS_LATE_LIMIT) begin
                    m_win   = 1'b0;
                    m_state = WAIT_FOR_SSB;
                end else if (!m_win && v && m_syms == `FS_SYM_PER_SF * `FS_SF_PER_FRAME - 1
                             && int'(m_cnt) == symlen - `FS_FIND_EARLY) begin
                    m_win = 1'b1;
                end
            end
        endcase

        if (locked && v) begin
            if (sym_end) begin
                {m_sfn, m_sf, m_sym, m_cp} = {a_sfn, a_sf, a_sym, a_cp};
                m_cnt  = '0;
                m_syms = m_syms + 1;
            end else begin
                {m_sfn, m_sf, m_sym, m_cp} = {e_sfn, e_sf, e_sym, e_cp};
                m_cnt = e_cnt + 1'b1;
            end
        end else if (acq || hit) begin
            {m_sfn, m_sf, m_sym, m_cp} = {e_sfn, e_sf, e_sym, e_cp};
            m_cnt = '0;
        end
        if (acq || hit) begin
            m_syms = 0;
        end
    endtask

    // compare everything at the falling edge, then drive the next cycle
    task automatic step(input logic v, input logic nid, input logic ibar);
        @(negedge clk);
        check_bit("m_axis_out_tvalid_o", out_valid, q2_valid);
        if (q2_valid) begin
            check_data("m_axis_out_tdata_o", out_data, q2_data);
            check_tag("m_axis_out_tuser_o", out_user, q2_tag);
        end
        check_bit("m_axis_out_tlast_o", out_last, q2_last);
        check_bit("symbol_start_o", sym_start, q2_first);
        check_bit("ssb_start_o", ssb_start, m_ssb);
        check_state("state_o", state, m_state);
        check_mismatch("sample_cnt_mismatch_o", mismatch, m_mismatch);
        apply(v, nid, ibar);
    endtask

    function automatic logic at_ssb_point(input int off);
        int symlen;
        symlen = `FS_FFT_LEN + int'(m_cp);
        if (off < 0) begin
            return m_win && int'(m_cnt) == symlen + off;
        end
        return m_win && int'(m_cnt) == off;
    endfunction

    initial begin
        int          n;
        logic        sent;
        logic [15:0] exp_missed;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        nid_valid  = 1'b0;
        ibar_valid = 1'b0;
        lfsr_q     = 32'h1838_e332;
        exp_missed = '0;
        m_state    = WAIT_FOR_SSB;
        m_win      = 1'b0;
        m_ssb      = 1'b0;
        m_mismatch = '0;
        {m_sfn, m_sf, m_sym, m_cp, m_cnt} = '0;
        m_syms     = 0;
        {q1_data, q2_data, q1_tag, q2_tag} = '0;
        {q1_valid, q2_valid, q1_last, q2_last, q1_first, q2_first} = '0;

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        check_bit("m_axis_out_tvalid_o", out_valid, 1'b0);
        check_bit("m_axis_out_tlast_o", out_last, 1'b0);
        check_bit("symbol_start_o", sym_start, 1'b0);
        check_bit("ssb_start_o", ssb_start, 1'b0);
        check_state("state_o", state, WAIT_FOR_SSB);
        check_mode("pss_detector_mode_o", pss_mode, SEARCH);
        check_count("missed_ssbs_o", missed_ssbs, 16'd0);
        apply(1'b0, 1'b0, 1'b0);
        repeat (4) step(1'b0, 1'b0, 1'b0);

        // acquisition with gaps in tvalid
        step(1'b1, 1'b1, 1'b0);
        n = 0;
        while (state != WAIT_FOR_IBAR || pss_mode != PAUSE) begin
            step(lfsr_bit(), 1'b0, 1'b0);
            n++;
            if (n > SHORT_TIMEOUT) timeout_fail("WAIT_FOR_IBAR and PAUSE after N_id_2");
        end
        repeat (40) step(lfsr_bit(), 1'b0, 1'b0);
        step(1'b1, 1'b0, 1'b1);
        n = 0;
        while (state != SYNCED) begin
            step(1'b1, 1'b0, 1'b0);
            n++;
            if (n > SHORT_TIMEOUT) timeout_fail("SYNCED after the ibar strobe");
        end

        for (int r = 0; r < 4; r++) begin
            if (row_missing[r]) begin
                exp_missed = exp_missed + 16'd1;
                n = 0;
                while (state != WAIT_FOR_SSB) begin
                    step(1'b1, 1'b0, 1'b0);
                    n++;
                    if (n > PERIOD_TIMEOUT) timeout_fail("loss of lock on a missing SSB");
                end
                // detector keeps looking until the late tolerance runs out
                check_mode("pss_detector_mode_o", pss_mode, FIND);
                n = 0;
                while (pss_mode != SEARCH) begin
                    step(1'b1, 1'b0, 1'b0);
                    n++;
                    if (n > SHORT_TIMEOUT) timeout_fail("SEARCH mode after a missing SSB");
                end
                check_count("missed_ssbs_o", missed_ssbs, exp_missed);
            end else begin
                sent = 1'b0;
                n    = 0;
                while (!sent) begin
                    if (at_ssb_point(row_offset[r])) begin
                        check_mode("pss_detector_mode_o", pss_mode, FIND);
                        step(1'b1, 1'b1, 1'b0);
                        sent = 1'b1;
                    end else begin
                        step(1'b1, 1'b0, 1'b0);
                    end
                    n++;
                    if (n > PERIOD_TIMEOUT) timeout_fail("the find window of the next SSB");
                end
                step(1'b1, 1'b0, 1'b0);
                check_bit("ssb_start_o", ssb_start, 1'b1);
                check_mismatch("sample_cnt_mismatch_o", mismatch, row_mismatch[r]);
                step(1'b1, 1'b0, 1'b0);
                check_mode("pss_detector_mode_o", pss_mode, PAUSE);
                check_count("missed_ssbs_o", missed_ssbs, exp_missed);
            end
        end
        repeat (600) step(1'b1, 1'b0, 1'b0);

        $display("Test OK");
        $finish;
    end

endmodule

//--- verilog/frame_sync.sv
`include "frame_sync_config.svh"

module frame_sync (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic [`FS_IN_DW-1:0]        s_axis_in_tdata_i,
    input  logic                        s_axis_in_tvalid_i,
    input  logic                        n_id_2_valid_i,
    input  logic                        ibar_ssb_valid_i,
    output frame_sync_pkg::pss_mode_t   pss_detector_mode_o,
    output logic [`FS_IN_DW-1:0]        m_axis_out_tdata_o,
    output logic [23:0]                 m_axis_out_tuser_o,
    output logic                        m_axis_out_tlast_o,
    output logic                        m_axis_out_tvalid_o,
    output logic                        symbol_start_o,
    output logic                        ssb_start_o,
    output frame_sync_pkg::sync_state_t state_o,
    output frame_sync_pkg::mismatch_t   sample_cnt_mismatch_o,
    output logic [15:0]                 missed_ssbs_o
);

    frame_timing_if timing_if (
        .clk_i(clk_i)
    );

    // detector control runs alongside the timer from the same strobes
    pss_scheduler u_pss_scheduler (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .n_id_2_valid_i(n_id_2_valid_i),
        .pss_mode_o    (pss_detector_mode_o),
        .missed_ssbs_o (missed_ssbs_o)
    );

    symbol_timer u_symbol_timer (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .s_axis_in_tvalid_i(s_axis_in_tvalid_i),
        .n_id_2_valid_i    (n_id_2_valid_i),
        .ibar_ssb_valid_i  (ibar_ssb_valid_i),
        .state_o           (state_o),
        .ssb_start_o       (ssb_start_o),
        .mismatch_o        (sample_cnt_mismatch_o),
        .timing            (timing_if.timer)
    );

    frame_tagger u_frame_tagger (
        .clk_i              (clk_i),
        .reset_ni           (reset_ni),
        .s_axis_in_tdata_i  (s_axis_in_tdata_i),
        .timing             (timing_if.tagger),
        .m_axis_out_tdata_o (m_axis_out_tdata_o),
        .m_axis_out_tuser_o (m_axis_out_tuser_o),
        .m_axis_out_tlast_o (m_axis_out_tlast_o),
        .m_axis_out_tvalid_o(m_axis_out_tvalid_o),
        .symbol_start_o     (symbol_start_o)
    );

endmodule

//--- verilog/frame_sync_config.svh
`ifndef FRAME_SYNC_CONFIG_SVH
`define FRAME_SYNC_CONFIG_SVH

// sample word
`define FS_IN_DW 32

// FFT and cyclic prefix lengths in samples
`define FS_NFFT 8
`define FS_FFT_LEN 256
`define FS_CP1_LEN 20
`define FS_CP2_LEN 18

// frame structure
`define FS_SYM_PER_SF 14
`define FS_SF_PER_FRAME 20
`define FS_SFN_MAX 1023

// one sample per clock
`define FS_CLK_FREQ 3840000
`define FS_CLKS_20MS 76800
// PSS detector wakes up 0.1 ms early and waits 0.1 ms past the expected SSB
`define FS_CLKS_EARLY 384
`define FS_CLKS_LATE 384

// find window around the expected SSB
`define FS_FIND_EARLY 4
`define FS_LATE_LIMIT 3

`endif

//--- verilog/frame_sync_pkg.sv
package frame_sync_pkg;

    // acquisition state of the symbol timer
    typedef enum logic [1:0] {
        WAIT_FOR_SSB  = 2'd0,
        WAIT_FOR_IBAR = 2'd1,
        SYNCED        = 2'd2
    } sync_state_t;

    // mode requested from the PSS detector
    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FIND   = 2'd1,
        PAUSE  = 2'd2
    } pss_mode_t;

    // timing counters
    typedef logic [9:0] sfn_t;
    typedef logic [4:0] subframe_t;
    typedef logic [3:0] symbol_t;
    typedef logic [4:0] cp_len_t;

    // position inside a symbol, CP included
    typedef logic [8:0] sample_cnt_t;

    // samples early (negative) or late (positive)
    typedef logic signed [7:0] mismatch_t;

endpackage

//--- verilog/frame_tagger.sv
`include "frame_sync_config.svh"

module frame_tagger (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic [`FS_IN_DW-1:0] s_axis_in_tdata_i,
    frame_timing_if.tagger       timing,
    output logic [`FS_IN_DW-1:0] m_axis_out_tdata_o,
    output logic [23:0]          m_axis_out_tuser_o,
    output logic                 m_axis_out_tlast_o,
    output logic                 m_axis_out_tvalid_o,
    output logic                 symbol_start_o
);
    import frame_sync_pkg::*;

    logic [`FS_IN_DW-1:0] data_q;
    sample_cnt_t          last_cnt;

    // last sample index of the symbol being tagged
    assign last_cnt = sample_cnt_t'(`FS_FFT_LEN + timing.cp_len - 1);

    // first stage lines the data up with the timer output
    always_ff @(posedge clk_i) begin
        data_q             <= s_axis_in_tdata_i;
        m_axis_out_tdata_o <= data_q;
        m_axis_out_tuser_o <= {timing.sfn, timing.subframe, timing.symbol, timing.cp_len};
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            m_axis_out_tvalid_o <= 1'b0;
            m_axis_out_tlast_o  <= 1'b0;
            symbol_start_o      <= 1'b0;
        end else begin
            m_axis_out_tvalid_o <= timing.sample_valid;
            m_axis_out_tlast_o  <= timing.sample_valid && (timing.sample_cnt == last_cnt);
            // lock condition already folded into sym_first
            symbol_start_o      <= timing.sym_first;
        end
    end

endmodule

//--- verilog/frame_timing_if.sv
interface frame_timing_if (
    input logic clk_i
);
    import frame_sync_pkg::*;

    // position of the sample that was accepted one cycle earlier
    sfn_t        sfn;
    subframe_t   subframe;
    symbol_t     symbol;
    cp_len_t     cp_len;
    sample_cnt_t sample_cnt;
    logic        sample_valid;
    // first sample of a symbol while locked
    logic        sym_first;

    modport timer (
        input  clk_i,
        output sfn, subframe, symbol, cp_len, sample_cnt, sample_valid, sym_first
    );

    modport tagger (
        input clk_i, sfn, subframe, symbol, cp_len, sample_cnt, sample_valid, sym_first
    );

endinterface

//--- verilog/pss_scheduler.sv
`include "frame_sync_config.svh"

module pss_scheduler (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      n_id_2_valid_i,
    output frame_sync_pkg::pss_mode_t pss_mode_o,
    output logic [15:0]               missed_ssbs_o
);
    import frame_sync_pkg::*;

    localparam int CLK_CNT_W = $clog2(`FS_CLKS_20MS + `FS_CLKS_LATE + 1);

    pss_mode_t            pss_state;
    logic [CLK_CNT_W-1:0] clks_since_ssb;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pss_state      <= SEARCH;
            pss_mode_o     <= SEARCH;
            clks_since_ssb <= '0;
            missed_ssbs_o  <= '0;
        end else begin
            // detector sees the state one cycle later
            pss_mode_o <= pss_state;
            case (pss_state)
                SEARCH: begin
                    // any N_id_2 is accepted here
                    if (n_id_2_valid_i) begin
                        missed_ssbs_o  <= '0;
                        clks_since_ssb <= CLK_CNT_W'(1);
                        pss_state      <= PAUSE;
                    end
                end
                PAUSE: begin
                    clks_since_ssb <= clks_since_ssb + 1'b1;
                    // sleep until shortly before the next SSB
                    if (clks_since_ssb > CLK_CNT_W'(`FS_CLKS_20MS - `FS_CLKS_EARLY)) begin
                        pss_state <= FIND;
                    end
                end
                FIND: begin
                    if (clks_since_ssb > CLK_CNT_W'(`FS_CLKS_20MS + `FS_CLKS_LATE)) begin
                        // SSB did not show up in time
                        missed_ssbs_o <= missed_ssbs_o + 1'b1;
                        pss_state     <= SEARCH;
                    end else if (n_id_2_valid_i) begin
                        clks_since_ssb <= CLK_CNT_W'(1);
                        pss_state      <= PAUSE;
                    end else begin
                        clks_since_ssb <= clks_since_ssb + 1'b1;
                    end
                end
                default: begin
                    pss_state <= SEARCH;
                end
            endcase
        end
    end

endmodule

//--- verilog/symbol_timer.sv
`include "frame_sync_config.svh"

module symbol_timer (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic                        s_axis_in_tvalid_i,
    input  logic                        n_id_2_valid_i,
    input  logic                        ibar_ssb_valid_i,
    output frame_sync_pkg::sync_state_t state_o,
    output logic                        ssb_start_o,
    output frame_sync_pkg::mismatch_t   mismatch_o,
    frame_timing_if.timer               timing
);
    import frame_sync_pkg::*;

    localparam int SYMS_BTWN_SSB = `FS_SYM_PER_SF * `FS_SF_PER_FRAME;

    // position of the next sample to be accepted
    sfn_t        sfn_q;
    subframe_t   subframe_q;
    symbol_t     symbol_q;
    cp_len_t     cp_len_q;
    sample_cnt_t sample_cnt_q;
    logic [8:0]  syms_since_ssb_q;
    logic        window_q;
    sample_cnt_t sym_len;

    // start of the following symbol
    sfn_t        adv_sfn;
    subframe_t   adv_subframe;
    symbol_t     adv_symbol;
    cp_len_t     adv_cp_len;

    // position given to the sample at the input this cycle
    sfn_t        eff_sfn;
    subframe_t   eff_subframe;
    symbol_t     eff_symbol;
    cp_len_t     eff_cp_len;
    sample_cnt_t eff_cnt;

    logic        locked;
    logic        in_window;
    logic        acq_hit;
    logic        ssb_hit;
    logic        ssb_late;
    logic        sym_end;

    assign sym_len   = sample_cnt_t'(`FS_FFT_LEN + cp_len_q);
    assign ssb_late  = sample_cnt_q < sample_cnt_t'(`FS_LATE_LIMIT);
    assign in_window = window_q &&
                       (ssb_late || sample_cnt_q >= sym_len - sample_cnt_t'(`FS_FIND_EARLY));
    assign acq_hit   = (state_o == WAIT_FOR_SSB) && n_id_2_valid_i;
    assign ssb_hit   = in_window && n_id_2_valid_i;
    assign locked    = (state_o != WAIT_FOR_SSB) || acq_hit;

    always_comb begin
        adv_sfn      = sfn_q;
        adv_subframe = subframe_q;
        if (symbol_q == symbol_t'(`FS_SYM_PER_SF - 1)) begin
            adv_symbol = '0;
            if (subframe_q == subframe_t'(`FS_SF_PER_FRAME - 1)) begin
                adv_subframe = '0;
                adv_sfn      = (sfn_q == sfn_t'(`FS_SFN_MAX - 1)) ? '0 : sfn_q + 1'b1;
            end else begin
                adv_subframe = subframe_q + 1'b1;
            end
        end else begin
            adv_symbol = symbol_q + 1'b1;
        end
        // long CP ahead of symbols 0 and 7
        if (adv_symbol == 4'd0 || adv_symbol == 4'd7) begin
            adv_cp_len = cp_len_t'(`FS_CP1_LEN);
        end else begin
            adv_cp_len = cp_len_t'(`FS_CP2_LEN);
        end
    end

    always_comb begin
        eff_sfn      = sfn_q;
        eff_subframe = subframe_q;
        eff_symbol   = symbol_q;
        eff_cp_len   = cp_len_q;
        eff_cnt      = sample_cnt_q;
        if (acq_hit) begin
            // first PSS is taken as symbol 2 of the SSB burst
            eff_symbol = 4'd2;
            eff_cp_len = cp_len_t'(`FS_CP2_LEN);
            eff_cnt    = '0;
        end else if (ssb_hit) begin
            // a late strobe restarts the current symbol and an early one jumps ahead
            eff_cnt = '0;
            if (!ssb_late) begin
                eff_sfn      = adv_sfn;
                eff_subframe = adv_subframe;
                eff_symbol   = adv_symbol;
                eff_cp_len   = adv_cp_len;
            end
        end
        sym_end = eff_cnt == sample_cnt_t'(`FS_FFT_LEN + eff_cp_len - 1);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_o          <= WAIT_FOR_SSB;
            ssb_start_o      <= 1'b0;
            mismatch_o       <= '0;
            window_q         <= 1'b0;
            sfn_q            <= '0;
            subframe_q       <= '0;
            symbol_q         <= '0;
            cp_len_q         <= '0;
            sample_cnt_q     <= '0;
            syms_since_ssb_q <= '0;
        end else begin
            ssb_start_o <= ssb_hit;

            if (locked && s_axis_in_tvalid_i) begin
                if (sym_end) begin
                    sfn_q            <= adv_sfn;
                    subframe_q       <= adv_subframe;
                    symbol_q         <= adv_symbol;
                    cp_len_q         <= adv_cp_len;
                    sample_cnt_q     <= '0;
                    syms_since_ssb_q <= syms_since_ssb_q + 1'b1;
                end else begin
                    sfn_q        <= eff_sfn;
                    subframe_q   <= eff_subframe;
                    symbol_q     <= eff_symbol;
                    cp_len_q     <= eff_cp_len;
                    sample_cnt_q <= eff_cnt + 1'b1;
                end
            end else if (acq_hit || ssb_hit) begin
                // the next sample opens the symbol when the strobe has no sample
                sfn_q        <= eff_sfn;
                subframe_q   <= eff_subframe;
                symbol_q     <= eff_symbol;
                cp_len_q     <= eff_cp_len;
                sample_cnt_q <= '0;
            end
            if (acq_hit || ssb_hit) begin
                syms_since_ssb_q <= '0;
            end

            case (state_o)
                WAIT_FOR_SSB: begin
                    if (n_id_2_valid_i) begin
                        state_o <= WAIT_FOR_IBAR;
                    end
                end
                WAIT_FOR_IBAR: begin
                    if (ibar_ssb_valid_i) begin
                        state_o <= SYNCED;
                    end
                end
                SYNCED: begin
                    if (ssb_hit) begin
                        window_q <= 1'b0;
                        if (sample_cnt_q == '0) begin
                            mismatch_o <= '0;
                        end else if (ssb_late) begin
                            mismatch_o <= mismatch_t'(sample_cnt_q);
                        end else begin
                            mismatch_o <= mismatch_t'(sample_cnt_q - sym_len);
                        end
                    end else if (window_q && s_axis_in_tvalid_i &&
                                 sample_cnt_q == sample_cnt_t'(`FS_LATE_LIMIT)) begin
                        // SSB lost so acquisition starts over
                        window_q <= 1'b0;
                        state_o  <= WAIT_FOR_SSB;
                    end else if (!window_q && s_axis_in_tvalid_i &&
                                 syms_since_ssb_q == 9'(SYMS_BTWN_SSB - 1) &&
                                 sample_cnt_q == sym_len - sample_cnt_t'(`FS_FIND_EARLY)) begin
                        window_q <= 1'b1;
                    end
                end
                default: begin
                    state_o <= WAIT_FOR_SSB;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            timing.sample_valid <= 1'b0;
            timing.sym_first    <= 1'b0;
        end else begin
            timing.sample_valid <= s_axis_in_tvalid_i;
            timing.sym_first    <= locked && s_axis_in_tvalid_i && (eff_cnt == '0);
        end
    end

    // tag of the accepted sample
    always_ff @(posedge clk_i) begin
        timing.sfn        <= eff_sfn;
        timing.subframe   <= eff_subframe;
        timing.symbol     <= eff_symbol;
        timing.cp_len     <= eff_cp_len;
        timing.sample_cnt <= eff_cnt;
    end

endmodule
